//--- hdl/vertex_cu_control_settings.svh
`ifndef VERTEX_CU_CONTROL_SETTINGS_SVH
`define VERTEX_CU_CONTROL_SETTINGS_SVH

// Compute unit count and index width
`define NUM_VERTEX_CU 4
`define CU_ID_BITS 2

// Read command and response fields
`define ADDRESS_BITS 32
`define TAG_BITS 8
`define DATA_BITS 32

// Burst buffer sizing
`define READ_CMD_BUFFER_DEPTH 16
`define ALMOST_FULL_MARGIN 2

// Progress counters
`define VERTEX_COUNT_BITS 32
`define EDGE_COUNT_BITS 32

`endif

//--- hdl/cu_traffic_pkg.sv
`include "vertex_cu_control_settings.svh"

package cu_traffic_pkg;

	// Index of one vertex compute unit
	typedef logic [`CU_ID_BITS-1:0] cu_id_t;

	// Tag carried by a command and returned with its response
	typedef struct packed {
		cu_id_t                 cu_id;
		logic [`TAG_BITS-1:0]   sequence_tag;
	} command_tag_t;

	// One read command, 43 bits with the default widths
	typedef struct packed {
		logic                       valid;
		logic [`ADDRESS_BITS-1:0]   address;
		command_tag_t               tag;
	} read_command_t;

	// Read response from memory
	typedef struct packed {
		logic                   valid;
		command_tag_t           tag;
		logic [`DATA_BITS-1:0]  data;
	} read_response_t;

endpackage

//--- hdl/cu_progress_pkg.sv
`include "vertex_cu_control_settings.svh"

package cu_progress_pkg;

	// Fill state of a command buffer
	typedef struct packed {
		logic valid;
		logic empty;
		logic full;
		logic alfull;
	} buffer_status_t;

	typedef logic [`VERTEX_COUNT_BITS-1:0] vertex_count_t;
	typedef logic [`EDGE_COUNT_BITS-1:0] edge_count_t;

endpackage

//--- hdl/read_command_arbiter.sv
`timescale 1ns/1ps

`include "vertex_cu_control_settings.svh"

module read_command_arbiter (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enabled,
	input  cu_traffic_pkg::read_command_t commands_in [0:`NUM_VERTEX_CU-1],
	input  logic [`NUM_VERTEX_CU-1:0]     requests,
	input  logic                          buffer_alfull,
	output cu_traffic_pkg::read_command_t command_out,
	output logic [`NUM_VERTEX_CU-1:0]     ready
);

	import cu_traffic_pkg::*;

	localparam int NUM_CU = `NUM_VERTEX_CU;

	cu_id_t        pointer;
	cu_id_t        candidate;
	cu_id_t        grant_index;
	logic          grant_found;
	logic          command_valid;
	read_command_t command_held;

	// First requester at or after the pointer
	always_comb begin
		grant_found = 1'b0;
		grant_index = pointer;
		candidate   = pointer;
		for (int offset = 0; offset < NUM_CU; offset++) begin
			candidate = cu_id_t'((int'(pointer) + offset) % NUM_CU);
			if (!grant_found && requests[candidate]) begin
				grant_found = 1'b1;
				grant_index = candidate;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pointer       <= '0;
			command_valid <= 1'b0;
			ready         <= '0;
		end else begin
			command_valid <= enabled && grant_found;
			ready         <= {NUM_CU{enabled && !buffer_alfull}};
			// Next round starts just past the winner
			if (enabled && grant_found) begin
				pointer <= (int'(grant_index) == NUM_CU - 1) ? '0 : cu_id_t'(grant_index + 1'b1);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (grant_found) begin
			command_held <= commands_in[grant_index];
		end
	end

	always_comb begin
		command_out       = command_held;
		command_out.valid = command_valid;
	end

endmodule

//--- hdl/burst_command_buffer.sv
`timescale 1ns/1ps

`include "vertex_cu_control_settings.svh"

module burst_command_buffer (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enabled,
	input  cu_traffic_pkg::read_command_t  push_command,
	input  logic                           bus_grant,
	input  cu_progress_pkg::buffer_status_t host_status,
	output cu_traffic_pkg::read_command_t  command_out,
	output logic                           bus_request,
	output cu_progress_pkg::buffer_status_t buffer_status
);

	import cu_traffic_pkg::*;

	localparam int DEPTH     = `READ_CMD_BUFFER_DEPTH;
	localparam int PTR_BITS  = $clog2(DEPTH);
	localparam int ALFULL_AT = DEPTH - `ALMOST_FULL_MARGIN;

	read_command_t       storage [0:DEPTH-1];
	logic [PTR_BITS-1:0] write_ptr;
	logic [PTR_BITS-1:0] read_ptr;
	logic [PTR_BITS:0]   count;
	logic                grant_q;
	logic                push;
	logic                pop;
	logic                out_valid;
	read_command_t       out_held;

	assign buffer_status.empty  = (count == '0);
	assign buffer_status.full   = (count == (PTR_BITS+1)'(DEPTH));
	assign buffer_status.alfull = (count >= (PTR_BITS+1)'(ALFULL_AT));
	assign buffer_status.valid  = !buffer_status.empty;

	assign push = push_command.valid && !buffer_status.full;
	// Pop only on a registered grant while the host still has room
	assign pop  = grant_q && !host_status.alfull && !buffer_status.empty;

	////////////////////////////////////////////////////////////////////////////
	// Circular FIFO pointers and fill level
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_ptr <= '0;
			read_ptr  <= '0;
			count     <= '0;
		end else begin
			if (push) begin
				write_ptr <= (int'(write_ptr) == DEPTH - 1) ? '0 : write_ptr + 1'b1;
			end
			if (pop) begin
				read_ptr <= (int'(read_ptr) == DEPTH - 1) ? '0 : read_ptr + 1'b1;
			end
			count <= count + (PTR_BITS+1)'(push) - (PTR_BITS+1)'(pop);
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			storage[write_ptr] <= push_command;
		end
		if (pop) begin
			out_held <= storage[read_ptr];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus request and grant
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_q     <= 1'b0;
			bus_request <= 1'b0;
			out_valid   <= 1'b0;
		end else begin
			grant_q     <= enabled && bus_grant;
			bus_request <= enabled && !buffer_status.empty && !host_status.alfull;
			out_valid   <= pop;
		end
	end

	always_comb begin
		command_out       = out_held;
		command_out.valid = out_valid;
	end

endmodule

//--- hdl/response_router.sv
`timescale 1ns/1ps

`include "vertex_cu_control_settings.svh"

module response_router (
	input  logic                           clock,
	input  logic                           rstn,
	input  cu_traffic_pkg::read_response_t response_in,
	output cu_traffic_pkg::read_response_t response_cu_out [0:`NUM_VERTEX_CU-1]
);

	import cu_traffic_pkg::*;

	localparam int NUM_CU = `NUM_VERTEX_CU;

	logic                response_valid_q;
	read_response_t      response_q;
	logic [NUM_CU-1:0]   cu_valid;
	read_response_t      routed;

	// Input stage
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_valid_q <= 1'b0;
		end else begin
			response_valid_q <= response_in.valid;
		end
	end

	// Payload is shared, only the valid is decoded per CU
	always_ff @(posedge clock) begin
		response_q <= response_in;
		routed     <= response_q;
	end

	for (genvar i = 0; i < NUM_CU; i++) begin : gen_route
		always_ff @(posedge clock or negedge rstn) begin
			if (!rstn) begin
				cu_valid[i] <= 1'b0;
			end else begin
				cu_valid[i] <= response_valid_q && (response_q.tag.cu_id == cu_id_t'(i));
			end
		end

		always_comb begin
			response_cu_out[i]       = routed;
			response_cu_out[i].valid = cu_valid[i];
		end
	end

endmodule

//--- hdl/job_counter_reduce.sv
`timescale 1ns/1ps

`include "vertex_cu_control_settings.svh"

module job_counter_reduce (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enabled,
	input  cu_progress_pkg::vertex_count_t vertex_counts_in [0:`NUM_VERTEX_CU-1],
	input  cu_progress_pkg::edge_count_t   edge_counts_in [0:`NUM_VERTEX_CU-1],
	output cu_progress_pkg::vertex_count_t vertex_total_out,
	output cu_progress_pkg::edge_count_t   edge_total_out
);

	import cu_progress_pkg::*;

	localparam int NUM_CU = `NUM_VERTEX_CU;

	vertex_count_t vertex_q [0:NUM_CU-1];
	edge_count_t   edge_q [0:NUM_CU-1];
	vertex_count_t vertex_sum;
	edge_count_t   edge_sum;

	// Sums wrap at the counter width
	always_comb begin
		vertex_sum = '0;
		edge_sum   = '0;
		for (int i = 0; i < NUM_CU; i++) begin
			vertex_sum = vertex_sum + vertex_q[i];
			edge_sum   = edge_sum + edge_q[i];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < NUM_CU; i++) begin
				vertex_q[i] <= '0;
				edge_q[i]   <= '0;
			end
			vertex_total_out <= '0;
			edge_total_out   <= '0;
		end else if (enabled) begin
			vertex_q         <= vertex_counts_in;
			edge_q           <= edge_counts_in;
			vertex_total_out <= vertex_sum;
			edge_total_out   <= edge_sum;
		end
	end

endmodule

//--- hdl/vertex_cu_control.sv
`timescale 1ns/1ps

`include "vertex_cu_control_settings.svh"

module vertex_cu_control (
	input  logic                            clock,
	input  logic                            rstn,
	input  logic                            enabled_in,
	input  cu_traffic_pkg::read_command_t   read_command_cu_in [0:`NUM_VERTEX_CU-1],
	input  logic [`NUM_VERTEX_CU-1:0]       request_read_command_cu_in,
	output logic [`NUM_VERTEX_CU-1:0]       ready_read_command_cu_out,
	input  logic                            read_command_bus_grant,
	output logic                            read_command_bus_request,
	output cu_traffic_pkg::read_command_t   read_command_out,
	input  cu_progress_pkg::buffer_status_t host_read_buffer_status,
	input  cu_traffic_pkg::read_response_t  read_response_in,
	output cu_traffic_pkg::read_response_t  read_response_cu_out [0:`NUM_VERTEX_CU-1],
	input  cu_progress_pkg::vertex_count_t  vertex_count_cu_in [0:`NUM_VERTEX_CU-1],
	input  cu_progress_pkg::edge_count_t    edge_count_cu_in [0:`NUM_VERTEX_CU-1],
	output cu_progress_pkg::vertex_count_t  vertex_count_done_out,
	output cu_progress_pkg::edge_count_t    edge_count_done_out
);

	import cu_traffic_pkg::*;
	import cu_progress_pkg::*;

	logic           enabled;
	read_command_t  arbiter_command;
	buffer_status_t burst_status;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read command path
	////////////////////////////////////////////////////////////////////////////

	read_command_arbiter i_read_command_arbiter (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.commands_in  (read_command_cu_in),
		.requests     (request_read_command_cu_in),
		.buffer_alfull(burst_status.alfull),
		.command_out  (arbiter_command),
		.ready        (ready_read_command_cu_out)
	);

	burst_command_buffer i_burst_command_buffer (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.push_command (arbiter_command),
		.bus_grant    (read_command_bus_grant),
		.host_status  (host_read_buffer_status),
		.command_out  (read_command_out),
		.bus_request  (read_command_bus_request),
		.buffer_status(burst_status)
	);

	////////////////////////////////////////////////////////////////////////////
	// Responses and progress
	////////////////////////////////////////////////////////////////////////////

	response_router i_response_router (
		.clock          (clock),
		.rstn           (rstn),
		.response_in    (read_response_in),
		.response_cu_out(read_response_cu_out)
	);

	job_counter_reduce i_job_counter_reduce (
		.clock           (clock),
		.rstn            (rstn),
		.enabled         (enabled),
		.vertex_counts_in(vertex_count_cu_in),
		.edge_counts_in  (edge_count_cu_in),
		.vertex_total_out(vertex_count_done_out),
		.edge_total_out  (edge_count_done_out)
	);

endmodule

//--- verif/vertex_cu_control_assertions.sv
`timescale 1ns/1ps

`include "vertex_cu_control_settings.svh"

module vertex_cu_control_assertions (
	input logic                            clock,
	input logic                            rstn,
	input logic                            read_command_bus_grant,
	input logic                            read_command_bus_request,
	input cu_traffic_pkg::read_command_t   read_command_out,
	input cu_progress_pkg::buffer_status_t host_read_buffer_status,
	input cu_traffic_pkg::read_response_t  read_response_cu_out [0:`NUM_VERTEX_CU-1]
);

	logic [`NUM_VERTEX_CU-1:0] response_valids;
	// Failed assertion count
	int unsigned               failure_count = 0;

	always_comb begin
		for (int i = 0; i < `NUM_VERTEX_CU; i++) begin
			response_valids[i] = read_response_cu_out[i].valid;
		end
	end

	// Request is registered, so it falls one cycle after the host fills up
	host_full_blocks_request: assert property (
		@(posedge clock) disable iff (!rstn)
		host_read_buffer_status.alfull |=> !read_command_bus_request
	) else begin
		failure_count++;
		$error("bus request raised while the host buffer is almost full");
	end

	one_response_owner: assert property (
		@(posedge clock) disable iff (!rstn)
		$onehot0(response_valids)
	) else begin
		failure_count++;
		$error("more than one CU received the same read response");
	end

	// Registered grant, then registered pop result
	command_follows_grant: assert property (
		@(posedge clock) disable iff (!rstn)
		read_command_out.valid |-> $past(read_command_bus_grant, 2)
	) else begin
		failure_count++;
		$error("read command left the buffer without a bus grant");
	end

endmodule

bind vertex_cu_control vertex_cu_control_assertions i_vertex_cu_control_assertions (
	.clock                   (clock),
	.rstn                    (rstn),
	.read_command_bus_grant  (read_command_bus_grant),
	.read_command_bus_request(read_command_bus_request),
	.read_command_out        (read_command_out),
	.host_read_buffer_status (host_read_buffer_status),
	.read_response_cu_out    (read_response_cu_out)
);

//--- verif/vertex_cu_control_tb.sv
`timescale 1ns/1ps

`include "vertex_cu_control_settings.svh"

module vertex_cu_control_tb;

	import cu_traffic_pkg::*;
	import cu_progress_pkg::*;

	localparam int NUM_CU = `NUM_VERTEX_CU;
	localparam int CLOCK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int WAIT_LIMIT = 32;
	localparam int RR_ROUNDS = 3;
	localparam int BACKPRESSURE_COMMANDS = `READ_CMD_BUFFER_DEPTH - `ALMOST_FULL_MARGIN;
	localparam int HOLD_CYCLES = 8;
	localparam int RESPONSE_COUNT = 24;
	localparam int COUNTER_ROUNDS = 4;
	localparam int COMMAND_COUNT = 1 + RR_ROUNDS * NUM_CU + BACKPRESSURE_COMMANDS;
	// About ten cycles per command from request to read_command_out
	localparam int TEST_CYCLES = 3 * (RESET_CYCLES + 4) + COMMAND_COUNT * 10 + HOLD_CYCLES + 4
		+ RESPONSE_COUNT + 2 + COUNTER_ROUNDS * 4;
	localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 4 * WAIT_LIMIT;

	logic            clock = 1'b0;
	logic            rstn;
	logic            enabled_in;
	read_command_t   read_command_cu_in [0:NUM_CU-1];
	logic [NUM_CU-1:0] request_read_command_cu_in;
	logic [NUM_CU-1:0] ready_read_command_cu_out;
	logic            read_command_bus_grant;
	logic            read_command_bus_request;
	read_command_t   read_command_out;
	buffer_status_t  host_read_buffer_status;
	read_response_t  read_response_in;
	read_response_t  read_response_cu_out [0:NUM_CU-1];
	vertex_count_t   vertex_count_cu_in [0:NUM_CU-1];
	edge_count_t     edge_count_cu_in [0:NUM_CU-1];
	vertex_count_t   vertex_count_done_out;
	edge_count_t     edge_count_done_out;

	integer          seed = 32'h9c4a9f55;
	string           current_test = "startup";
	int              rr_pointer;
	read_command_t   expected_commands [$];

	vertex_cu_control i_vertex_cu_control (
		.clock                     (clock),
		.rstn                      (rstn),
		.enabled_in                (enabled_in),
		.read_command_cu_in        (read_command_cu_in),
		.request_read_command_cu_in(request_read_command_cu_in),
		.ready_read_command_cu_out (ready_read_command_cu_out),
		.read_command_bus_grant    (read_command_bus_grant),
		.read_command_bus_request  (read_command_bus_request),
		.read_command_out          (read_command_out),
		.host_read_buffer_status   (host_read_buffer_status),
		.read_response_in          (read_response_in),
		.read_response_cu_out      (read_response_cu_out),
		.vertex_count_cu_in        (vertex_count_cu_in),
		.edge_count_cu_in          (edge_count_cu_in),
		.vertex_count_done_out     (vertex_count_done_out),
		.edge_count_done_out       (edge_count_done_out)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting and compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	always @(i_vertex_cu_control.i_vertex_cu_control_assertions.failure_count) begin
		if (i_vertex_cu_control.i_vertex_cu_control_assertions.failure_count != 0) begin
			stop_with_failure("a bound assertion on the DUT failed");
		end
	end

	task automatic compare_command(input string what, input read_command_t expected,
			input read_command_t actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("** Error %s: %s expected %h actual %h",
				current_test, what, expected, actual));
		end
	endtask

	task automatic compare_response(input string what, input read_response_t expected,
			input read_response_t actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("** Error %s: %s expected %h actual %h",
				current_test, what, expected, actual));
		end
	endtask

	task automatic compare_vertex_count(input string what, input vertex_count_t expected,
			input vertex_count_t actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("** Error %s: %s expected %h actual %h",
				current_test, what, expected, actual));
		end
	endtask

	task automatic compare_edge_count(input string what, input edge_count_t expected,
			input edge_count_t actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("** Error %s: %s expected %h actual %h",
				current_test, what, expected, actual));
		end
	endtask

	task automatic compare_flag(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("** Error %s: %s expected %b actual %b",
				current_test, what, expected, actual));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// First requester at or after the pointer
	function automatic int round_robin_winner(input int pointer, input logic [NUM_CU-1:0] requests);
		int cu;
		for (int offset = 0; offset < NUM_CU; offset++) begin
			cu = (pointer + offset) % NUM_CU;
			if (requests[cu]) begin
				return cu;
			end
		end
		return -1;
	endfunction

	function automatic read_command_t make_command(input int cu, input int seq);
		read_command_t command;
		command.valid            = 1'b1;
		command.address          = $random(seed);
		command.tag.cu_id        = cu_id_t'(cu);
		command.tag.sequence_tag = seq[`TAG_BITS-1:0];
		return command;
	endfunction

	function automatic read_response_t make_response();
		read_response_t response;
		int             pick;
		pick                      = $random(seed);
		response.valid            = (pick[1:0] != 2'b00);
		response.tag.cu_id        = pick[`CU_ID_BITS+1:2];
		response.tag.sequence_tag = pick[15:8];
		response.data             = $random(seed);
		return response;
	endfunction

	task automatic reset_dut();
		@(posedge clock);
		rstn       <= 1'b0;
		enabled_in <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		rstn       <= 1'b1;
		rr_pointer = 0;
	endtask

	task automatic await_ready();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				stop_with_failure("CU ready did not rise while the buffer had room");
			end
		end while (ready_read_command_cu_out !== '1);
	endtask

	task automatic enable_dut();
		@(posedge clock);
		enabled_in <= 1'b1;
		await_ready();
	endtask

	task automatic await_bus_request();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				stop_with_failure("bus request never rose while commands were buffered");
			end
		end while (read_command_bus_request !== 1'b1);
	endtask

	task automatic await_command();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				stop_with_failure("no read command came out after a bus grant");
			end
		end while (read_command_out.valid !== 1'b1);
	endtask

	// One request from one CU for a single cycle
	task automatic issue_command(input int cu, input int seq);
		read_command_t command;
		command = make_command(cu, seq);
		@(posedge clock);
		read_command_cu_in[cu]     <= command;
		request_read_command_cu_in <= NUM_CU'(1) << cu;
		expected_commands.push_back(command);
		rr_pointer = (round_robin_winner(rr_pointer, NUM_CU'(1) << cu) + 1) % NUM_CU;
		@(posedge clock);
		request_read_command_cu_in <= '0;
	endtask

	// One grant pulse per buffered command
	task automatic drain_commands();
		read_command_t expected;
		while (expected_commands.size() > 0) begin
			expected = expected_commands.pop_front();
			await_bus_request();
			@(posedge clock);
			read_command_bus_grant <= 1'b1;
			@(posedge clock);
			read_command_bus_grant <= 1'b0;
			await_command();
			compare_command("read_command_out", expected, read_command_out);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic check_reset_state();
		current_test = "check_reset_state";
		@(negedge clock);
		compare_flag("any CU ready", 1'b0, |ready_read_command_cu_out);
		compare_flag("bus request", 1'b0, read_command_bus_request);
		compare_flag("command valid", 1'b0, read_command_out.valid);
		for (int cu = 0; cu < NUM_CU; cu++) begin
			compare_flag($sformatf("response valid of CU %0d", cu), 1'b0,
				read_response_cu_out[cu].valid);
		end
		compare_vertex_count("vertex total", '0, vertex_count_done_out);
		compare_edge_count("edge total", '0, edge_count_done_out);
	endtask

	task automatic send_single_command();
		current_test = "send_single_command";
		issue_command(2, 8'h5a);
		drain_commands();
	endtask

	task automatic rotate_all_requesters();
		read_command_t command;
		int            winner;
		current_test = "rotate_all_requesters";
		reset_dut();
		enable_dut();
		for (int cycle = 0; cycle < RR_ROUNDS * NUM_CU; cycle++) begin
			@(posedge clock);
			winner = round_robin_winner(rr_pointer, '1);
			for (int cu = 0; cu < NUM_CU; cu++) begin
				command = make_command(cu, cycle);
				read_command_cu_in[cu] <= command;
				if (cu == winner) begin
					expected_commands.push_back(command);
				end
			end
			request_read_command_cu_in <= '1;
			rr_pointer = (winner + 1) % NUM_CU;
		end
		@(posedge clock);
		request_read_command_cu_in <= '0;
		drain_commands();
	endtask

	task automatic hold_under_backpressure();
		current_test = "hold_under_backpressure";
		@(posedge clock);
		host_read_buffer_status.alfull <= 1'b1;
		// Fill the burst buffer up to its almost-full level
		for (int i = 0; i < BACKPRESSURE_COMMANDS; i++) begin
			@(negedge clock);
			compare_flag("all CUs ready", 1'b1, &ready_read_command_cu_out);
			issue_command(i % NUM_CU, 16 + i);
		end
		repeat (2) @(posedge clock);
		@(negedge clock);
		compare_flag("any CU ready", 1'b0, |ready_read_command_cu_out);
		// Grants keep coming but nothing may leave
		for (int cycle = 0; cycle < HOLD_CYCLES; cycle++) begin
			@(posedge clock);
			read_command_bus_grant <= 1'b1;
			@(negedge clock);
			compare_flag("bus request", 1'b0, read_command_bus_request);
			compare_flag("command valid", 1'b0, read_command_out.valid);
		end
		@(posedge clock);
		read_command_bus_grant <= 1'b0;
		repeat (2) @(posedge clock);
		host_read_buffer_status.alfull <= 1'b0;
		drain_commands();
		await_ready();
	endtask

	task automatic route_random_responses();
		read_response_t sent [0:RESPONSE_COUNT-1];
		read_response_t expected;
		current_test = "route_random_responses";
		for (int i = 0; i < RESPONSE_COUNT + 2; i++) begin
			@(posedge clock);
			if (i < RESPONSE_COUNT) begin
				sent[i] = make_response();
				read_response_in <= sent[i];
			end else begin
				read_response_in <= '0;
			end
			@(negedge clock);
			if (i >= 2) begin
				expected = sent[i-2];
				for (int cu = 0; cu < NUM_CU; cu++) begin
					if (expected.valid && int'(expected.tag.cu_id) == cu) begin
						compare_response($sformatf("response of CU %0d", cu), expected,
							read_response_cu_out[cu]);
					end else begin
						compare_flag($sformatf("response valid of CU %0d", cu), 1'b0,
							read_response_cu_out[cu].valid);
					end
				end
			end
		end
	endtask

	task automatic sum_held_counters();
		vertex_count_t vertex_sum;
		edge_count_t   edge_sum;
		vertex_count_t vertex_before;
		edge_count_t   edge_before;
		current_test = "sum_held_counters";
		// Counter inputs have stayed zero since reset
		vertex_before = '0;
		edge_before   = '0;
		for (int round = 0; round < COUNTER_ROUNDS; round++) begin
			vertex_sum = '0;
			edge_sum   = '0;
			@(posedge clock);
			for (int cu = 0; cu < NUM_CU; cu++) begin
				vertex_count_cu_in[cu] <= vertex_count_t'($random(seed));
				edge_count_cu_in[cu]   <= edge_count_t'($random(seed));
			end
			#1;
			for (int cu = 0; cu < NUM_CU; cu++) begin
				vertex_sum = vertex_sum + vertex_count_cu_in[cu];
				edge_sum   = edge_sum + edge_count_cu_in[cu];
			end
			// One cycle in, the totals still show the previous counters
			@(posedge clock);
			@(negedge clock);
			compare_vertex_count("vertex total after one cycle", vertex_before,
				vertex_count_done_out);
			compare_edge_count("edge total after one cycle", edge_before, edge_count_done_out);
			@(posedge clock);
			@(negedge clock);
			compare_vertex_count("vertex total", vertex_sum, vertex_count_done_out);
			compare_edge_count("edge total", edge_sum, edge_count_done_out);
			vertex_before = vertex_sum;
			edge_before   = edge_sum;
		end
	endtask

	initial begin
		rstn                       = 1'b0;
		enabled_in                 = 1'b0;
		request_read_command_cu_in = '0;
		read_command_bus_grant     = 1'b0;
		host_read_buffer_status    = '0;
		read_response_in           = '0;
		for (int cu = 0; cu < NUM_CU; cu++) begin
			read_command_cu_in[cu] = '0;
			vertex_count_cu_in[cu] = '0;
			edge_count_cu_in[cu]   = '0;
		end
		reset_dut();
		check_reset_state();
		enable_dut();
		send_single_command();
		rotate_all_requesters();
		hold_under_backpressure();
		route_random_responses();
		sum_held_counters();
		$display("All tests passed");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		stop_with_failure("watchdog expired before the tests finished");
	end

endmodule

//--- vertex_cu_control.f
+incdir+hdl
hdl/cu_traffic_pkg.sv
hdl/cu_progress_pkg.sv
hdl/read_command_arbiter.sv
hdl/burst_command_buffer.sv
hdl/response_router.sv
hdl/job_counter_reduce.sv
hdl/vertex_cu_control.sv
verif/vertex_cu_control_assertions.sv
verif/vertex_cu_control_tb.sv

//--- Bender.yml
package:
  name: vertex_cu_control

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cu_traffic_pkg.sv
      - hdl/cu_progress_pkg.sv
      - hdl/read_command_arbiter.sv
      - hdl/burst_command_buffer.sv
      - hdl/response_router.sv
      - hdl/job_counter_reduce.sv
      - hdl/vertex_cu_control.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/vertex_cu_control_assertions.sv
      - verif/vertex_cu_control_tb.sv
